//--- common/ex_pkg.sv
package ex_pkg;

    //////////////////////////////////////////////////
    // Widths
    //////////////////////////////////////////////////

    localparam int xlen         = 64;
    localparam int word_w       = 32;
    localparam int shamt_w      = $clog2(xlen);
    localparam int shamt_word_w = $clog2(word_w);

    //////////////////////////////////////////////////
    // ALU operation codes
    //////////////////////////////////////////////////

    // 13 and 14 are free and give zero
    typedef enum logic [3:0] {
        alu_add  = 4'd0,
        alu_sub  = 4'd1,
        alu_sll  = 4'd2,
        alu_srl  = 4'd3,
        alu_sra  = 4'd4,
        alu_xor  = 4'd5,
        alu_or   = 4'd6,
        alu_and  = 4'd7,
        alu_slt  = 4'd8,
        alu_sltu = 4'd9,
        alu_a    = 4'd10,
        alu_b    = 4'd11,
        alu_b4   = 4'd12,
        alu_idle = 4'd15
    } alu_op_t;

    // Branch conditions, funct3 encoding
    typedef enum logic [2:0] {
        br_eq  = 3'd0,
        br_ne  = 3'd1,
        br_lt  = 3'd4,
        br_ge  = 3'd5,
        br_ltu = 3'd6,
        br_geu = 3'd7
    } br_fun_t;

    // Load and store access types
    typedef enum logic [2:0] {
        ld_h  = 3'd0,
        ld_hu = 3'd1,
        ld_w  = 3'd2,
        ld_wu = 3'd3,
        ld_d  = 3'd4,
        st_h  = 3'd5,
        st_w  = 3'd6,
        st_d  = 3'd7
    } ldst_t;

    typedef enum logic [1:0] {
        mem_none  = 2'd0,
        mem_load  = 2'd1,
        mem_store = 2'd2
    } mem_ctl_t;

    //////////////////////////////////////////////////
    // Flush timing
    //////////////////////////////////////////////////

    // Counted in cache-ready cycles
    localparam int flush_hold     = 4;
    localparam int flush_int_hold = 6;
    localparam int pc_step        = 4;

endpackage

//--- alu/ex_alu.sv
`timescale 1ns/1ns

module ex_alu
    import ex_pkg::*;
(
    input  logic [xlen-1:0] a,
    input  logic [xlen-1:0] b,
    input  alu_op_t         alu_op,
    input  logic            op_32,
    output logic [xlen-1:0] wb_data
);

    logic [xlen-1:0]         add_d;
    logic [xlen-1:0]         sub_d;
    logic [xlen-1:0]         sll_d;
    logic [xlen-1:0]         srl_d;
    logic [xlen-1:0]         sra_d;
    logic [word_w-1:0]       add_w;
    logic [word_w-1:0]       sub_w;
    logic [word_w-1:0]       sll_w;
    logic [word_w-1:0]       srl_w;
    logic [word_w-1:0]       sra_w;
    logic [shamt_w-1:0]      shamt_d;
    logic [shamt_word_w-1:0] shamt_w32;

    function automatic logic [xlen-1:0] sext_word(input logic [word_w-1:0] w);
        sext_word = {{(xlen - word_w){w[word_w-1]}}, w};
    endfunction

    assign shamt_d   = a[shamt_w-1:0];
    assign shamt_w32 = a[shamt_word_w-1:0];

    //////////////////////////////////////////////////
    // Doubleword datapath
    //////////////////////////////////////////////////

    // Operand order follows the decoder with b on the rs1 side
    assign add_d = b + a;
    assign sub_d = b - a;
    assign sll_d = b << shamt_d;
    assign srl_d = b >> shamt_d;
    assign sra_d = $signed(b) >>> shamt_d;

    //////////////////////////////////////////////////
    // Word datapath
    //////////////////////////////////////////////////

    assign add_w = b[word_w-1:0] + a[word_w-1:0];
    assign sub_w = b[word_w-1:0] - a[word_w-1:0];
    assign sll_w = b[word_w-1:0] << shamt_w32;
    assign srl_w = b[word_w-1:0] >> shamt_w32;
    assign sra_w = $signed(b[word_w-1:0]) >>> shamt_w32;

    // Result select
    always_comb
    begin
        case (alu_op)
            alu_add:  wb_data = op_32 ? sext_word(add_w) : add_d;
            alu_sub:  wb_data = op_32 ? sext_word(sub_w) : sub_d;
            alu_sll:  wb_data = op_32 ? sext_word(sll_w) : sll_d;
            alu_srl:  wb_data = op_32 ? sext_word(srl_w) : srl_d;
            alu_sra:  wb_data = op_32 ? sext_word(sra_w) : sra_d;
            alu_xor:  wb_data = a ^ b;
            alu_or:   wb_data = a | b;
            alu_and:  wb_data = a & b;
            alu_slt:  wb_data = {{(xlen - 1){1'b0}}, $signed(b) < $signed(a)};
            alu_sltu: wb_data = {{(xlen - 1){1'b0}}, b < a};
            alu_a:    wb_data = a;
            alu_b:    wb_data = b;
            // Link address for jal/jalr
            alu_b4:   wb_data = b + xlen'(pc_step);
            default:  wb_data = '0;
        endcase
    end

endmodule

//--- branch/branch_unit.sv
`timescale 1ns/1ns

module branch_unit
    import ex_pkg::*;
(
    input  logic [xlen-1:0] comp1,
    input  logic [xlen-1:0] comp2,
    input  logic [xlen-1:0] jump_bus1,
    input  logic [xlen-1:0] jump_bus2,
    input  br_fun_t         fun3,
    input  logic            cbranch,
    input  logic            jump,
    input  logic            jumpr,
    input  logic            flush_internal,
    output logic            jump_final,
    output logic [xlen-1:0] jump_addr
);

    logic is_eq;
    logic is_lt;
    logic is_ltu;
    logic cond;
    logic taken;

    //////////////////////////////////////////////////
    // Comparator
    //////////////////////////////////////////////////

    assign is_eq  = comp1 == comp2;
    assign is_lt  = $signed(comp1) < $signed(comp2);
    assign is_ltu = comp1 < comp2;

    always_comb
    begin
        case (fun3)
            br_eq:   cond = is_eq;
            br_ne:   cond = !is_eq;
            br_lt:   cond = is_lt;
            br_ge:   cond = !is_lt;
            br_ltu:  cond = is_ltu;
            br_geu:  cond = !is_ltu;
            // 2 and 3 are not branches
            default: cond = 1'b0;
        endcase
    end

    //////////////////////////////////////////////////
    // Target and decision
    //////////////////////////////////////////////////

    // Base is pc for jal/branches, rs1 for jalr
    assign jump_addr = jump_bus1 + jump_bus2;

    assign taken = cbranch ? cond : (jump | jumpr);

    // No redirect from an instruction that is being flushed
    assign jump_final = taken & !flush_internal;

endmodule

//--- source/flush_control.sv
`timescale 1ns/1ns

module flush_control
    import ex_pkg::*;
(
    input  logic            CLK,
    input  logic            RST,
    input  logic            cache_ready,
    input  logic            stall_enable,
    input  logic            jump_final,
    input  logic [xlen-1:0] jump_addr,
    input  logic [xlen-1:0] pc_id_fb,
    input  logic [xlen-1:0] pc_fb_ex,
    output logic            flush,
    output logic            flush_internal,
    output logic            predicted
);

    logic [1:0]                          warm_up;
    logic [$clog2(flush_hold)-1:0]       flush_cnt;
    logic [$clog2(flush_int_hold)-1:0]   flush_int_cnt;
    logic [xlen-1:0]                     seq_pc;
    logic                                mispredict;

    assign seq_pc = pc_fb_ex + xlen'(pc_step);

    // Fetch PC against the resolved next PC
    always_comb
    begin
        if (jump_final)
            mispredict = pc_id_fb != jump_addr;
        else if (stall_enable && !flush_internal && warm_up[1])
            mispredict = pc_id_fb != seq_pc;
        else
            mispredict = 1'b0;
    end

    assign predicted = !(mispredict && cache_ready);

    //////////////////////////////////////////////////
    // Flush registers and hold counters
    //////////////////////////////////////////////////

    always_ff @(posedge CLK)
    begin
        if (RST)
        begin
            warm_up        <= '0;
            flush          <= 1'b0;
            flush_internal <= 1'b0;
            flush_cnt      <= '0;
            flush_int_cnt  <= '0;
        end
        else if (cache_ready)
        begin
            warm_up <= {warm_up[0], 1'b1};
            if (mispredict)
            begin
                flush          <= 1'b1;
                flush_internal <= 1'b1;
                flush_cnt      <= '0;
                flush_int_cnt  <= '0;
            end
            else
            begin
                if (flush)
                begin
                    if (flush_cnt == flush_hold - 1)
                    begin
                        flush     <= 1'b0;
                        flush_cnt <= '0;
                    end
                    else
                        flush_cnt <= flush_cnt + 1'b1;
                end
                if (flush_internal)
                begin
                    if (flush_int_cnt == flush_int_hold - 1)
                    begin
                        flush_internal <= 1'b0;
                        flush_int_cnt  <= '0;
                    end
                    else
                        flush_int_cnt <= flush_int_cnt + 1'b1;
                end
            end
        end
    end

    // Short flush always sits inside the long one
    a_flush_nested: assert property (@(posedge CLK) disable iff (RST)
        flush |-> flush_internal);

    a_cnt_range: assert property (@(posedge CLK) disable iff (RST)
        flush_int_cnt < flush_int_hold);

    // Counters rest at zero between flushes
    a_cnt_idle: assert property (@(posedge CLK) disable iff (RST)
        !flush_internal |-> (flush_cnt == '0) && (flush_int_cnt == '0));

    // Branch unit must not re-arm a flush in progress
    a_no_rearm: assert property (@(posedge CLK) disable iff (RST)
        flush_internal |-> !jump_final);

endmodule

//--- source/misalign_check.sv
`timescale 1ns/1ns

module misalign_check
    import ex_pkg::*;
(
    input  mem_ctl_t        mem_ctl,
    input  ldst_t           ldst_type,
    input  logic [xlen-1:0] addr,
    output logic            load_misaligned,
    output logic            store_misaligned
);

    logic [2:0] low;
    logic       half_bad;
    logic       word_bad;
    logic       dword_bad;

    assign low = addr[2:0];

    // Only accesses crossing the 8-byte line are flagged
    assign half_bad  = &low;
    assign word_bad  = low > 3'd4;
    assign dword_bad = |low;

    always_comb
    begin
        load_misaligned  = 1'b0;
        store_misaligned = 1'b0;
        case (ldst_type)
            ld_h, ld_hu: load_misaligned  = (mem_ctl == mem_load) && half_bad;
            ld_w, ld_wu: load_misaligned  = (mem_ctl == mem_load) && word_bad;
            ld_d:        load_misaligned  = (mem_ctl == mem_load) && dword_bad;
            st_h:        store_misaligned = (mem_ctl == mem_store) && half_bad;
            st_w:        store_misaligned = (mem_ctl == mem_store) && word_bad;
            st_d:        store_misaligned = (mem_ctl == mem_store) && dword_bad;
            default:     load_misaligned  = 1'b0;
        endcase
    end

endmodule

//--- source/ex_stage.sv
`timescale 1ns/1ns

module ex_stage
    import ex_pkg::*;
(
    input  logic            CLK,
    input  logic            RST,
    input  logic [xlen-1:0] a,
    input  logic [xlen-1:0] b,
    input  logic [xlen-1:0] comp1,
    input  logic [xlen-1:0] comp2,
    input  logic [xlen-1:0] jump_bus1,
    input  logic [xlen-1:0] jump_bus2,
    input  logic [xlen-1:0] pc_id_fb,
    input  logic [xlen-1:0] pc_fb_ex,
    input  alu_op_t         alu_op,
    input  logic            op_32,
    input  br_fun_t         fun3,
    input  logic            cbranch,
    input  logic            jump,
    input  logic            jumpr,
    input  logic            stall_enable,
    input  logic            cache_ready,
    input  mem_ctl_t        mem_ctl_in,
    input  logic [1:0]      type_in,
    input  ldst_t           ldst_type,
    output logic [xlen-1:0] wb_data,
    output logic [xlen-1:0] jump_addr,
    output logic            jump_final,
    output logic            flush,
    output logic            flush_internal,
    output logic            predicted,
    output mem_ctl_t        mem_ctl_out,
    output logic [1:0]      type_out,
    output logic            op_32_out,
    output logic            load_misaligned,
    output logic            store_misaligned
);

    ex_alu u_alu (
        .a       (a),
        .b       (b),
        .alu_op  (alu_op),
        .op_32   (op_32),
        .wb_data (wb_data)
    );

    branch_unit u_branch (
        .comp1          (comp1),
        .comp2          (comp2),
        .jump_bus1      (jump_bus1),
        .jump_bus2      (jump_bus2),
        .fun3           (fun3),
        .cbranch        (cbranch),
        .jump           (jump),
        .jumpr          (jumpr),
        .flush_internal (flush_internal),
        .jump_final     (jump_final),
        .jump_addr      (jump_addr)
    );

    flush_control u_flush (
        .CLK            (CLK),
        .RST            (RST),
        .cache_ready    (cache_ready),
        .stall_enable   (stall_enable),
        .jump_final     (jump_final),
        .jump_addr      (jump_addr),
        .pc_id_fb       (pc_id_fb),
        .pc_fb_ex       (pc_fb_ex),
        .flush          (flush),
        .flush_internal (flush_internal),
        .predicted      (predicted)
    );

    // ALU sum doubles as the memory address
    misalign_check u_misalign (
        .mem_ctl          (mem_ctl_in),
        .ldst_type        (ldst_type),
        .addr             (wb_data),
        .load_misaligned  (load_misaligned),
        .store_misaligned (store_misaligned)
    );

    //////////////////////////////////////////////////
    // Squash memory side while flushing
    //////////////////////////////////////////////////

    assign mem_ctl_out = flush_internal ? mem_none : mem_ctl_in;
    assign type_out    = type_in & {2{!flush_internal}};
    assign op_32_out   = op_32 & !flush_internal;

endmodule

//--- tests/tb_ex_stage.sv
`timescale 1ns/1ns

module tb_ex_stage
    import ex_pkg::*;
();

    logic            CLK;
    logic            RST;
    logic [xlen-1:0] a;
    logic [xlen-1:0] b;
    logic [xlen-1:0] comp1;
    logic [xlen-1:0] comp2;
    logic [xlen-1:0] jump_bus1;
    logic [xlen-1:0] jump_bus2;
    logic [xlen-1:0] pc_id_fb;
    logic [xlen-1:0] pc_fb_ex;
    alu_op_t         alu_op;
    logic            op_32;
    br_fun_t         fun3;
    logic            cbranch;
    logic            jump;
    logic            jumpr;
    logic            stall_enable;
    logic            cache_ready;
    mem_ctl_t        mem_ctl_in;
    logic [1:0]      type_in;
    ldst_t           ldst_type;
    logic [xlen-1:0] wb_data;
    logic [xlen-1:0] jump_addr;
    logic            jump_final;
    logic            flush;
    logic            flush_internal;
    logic            predicted;
    mem_ctl_t        mem_ctl_out;
    logic [1:0]      type_out;
    logic            op_32_out;
    logic            load_misaligned;
    logic            store_misaligned;

    int              fd;
    int              code;
    int              n_vec;
    logic            done;
    logic [7:0]      kind;
    logic [8*200-1:0] rest;
    logic [63:0]     f [0:11];

    ex_stage u_ex_stage (.*);

    always #5 CLK = ~CLK;

    //////////////////////////////////////////////////
    // Helpers
    //////////////////////////////////////////////////

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("TESTS FAILED");
        $fatal(1);
    endtask

    task automatic check_field(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        assert (got == exp)
        else
        begin
            $display("[FAIL] t=%0t %s got %h expected %h", $time, name, got, exp);
            $display("TESTS FAILED");
            $fatal(1);
        end
    endtask

    task automatic drive_idle();
        alu_op       = alu_idle;
        a            = '0;
        b            = '0;
        op_32        = 1'b0;
        fun3         = br_eq;
        cbranch      = 1'b0;
        jump         = 1'b0;
        jumpr        = 1'b0;
        stall_enable = 1'b0;
        cache_ready  = 1'b1;
        mem_ctl_in   = mem_none;
        type_in      = 2'b00;
        ldst_type    = ld_h;
        pc_id_fb     = '0;
        pc_fb_ex     = '0;
    endtask

    task automatic read_fields(input int n);
        int i;
        for (i = 0; i < n; i++)
        begin
            code = $fscanf(fd, "%h", f[i]);
            if (code != 1)
                abort_run("Trace line has fewer fields than its kind needs");
        end
    endtask

    task automatic wait_flush_clear();
        int n;
        n = 0;
        while (flush_internal)
        begin
            n++;
            if (n > 20)
                abort_run("Timed out waiting for flush_internal to clear");
            @(negedge CLK);
        end
    endtask

    //////////////////////////////////////////////////
    // Vector kinds
    //////////////////////////////////////////////////

    task automatic alu_vector();
        alu_op = alu_op_t'(f[0][3:0]);
        op_32  = f[1][0];
        a      = f[2];
        b      = f[3];
        #4;
        check_field("wb_data", wb_data, f[4]);
    endtask

    task automatic branch_vector();
        fun3         = br_fun_t'(f[0][2:0]);
        cbranch      = f[1][0];
        jump         = f[2][0];
        jumpr        = f[3][0];
        comp1        = f[4];
        comp2        = f[5];
        jump_bus1    = f[6];
        jump_bus2    = f[7];
        pc_id_fb     = f[8];
        // Jump base is the PC of the instruction in EX
        stall_enable = 1'b1;
        pc_fb_ex     = f[6];
        #4;
        check_field("jump_final", 64'(jump_final), f[9]);
        check_field("jump_addr", jump_addr, f[10]);
        check_field("predicted", 64'(predicted), f[11]);
    endtask

    task automatic flush_vector();
        logic [63:0] n_flush;
        logic [63:0] n_int;
        logic [63:0] cyc;
        n_flush    = '0;
        n_int      = '0;
        cyc        = '0;
        jump       = 1'b1;
        jump_bus1  = f[0];
        jump_bus2  = f[1];
        pc_id_fb   = f[2];
        mem_ctl_in = mem_load;
        type_in    = 2'b11;
        op_32      = 1'b1;
        #4;
        check_field("predicted", 64'(predicted), 64'd0);
        // Memory side passes through before the flush
        check_field("mem_ctl_out", 64'(mem_ctl_out), 64'(mem_load));
        check_field("type_out", 64'(type_out), 64'd3);
        check_field("op_32_out", 64'(op_32_out), 64'd1);
        @(negedge CLK);
        // Fetch now on the target, so jump_final after the flush is a hit
        pc_id_fb = f[0] + f[1];
        while (flush_internal)
        begin
            cache_ready = (cyc < f[3]) ? 1'b0 : 1'b1;
            if (flush)
                n_flush = n_flush + 1;
            n_int = n_int + 1;
            check_field("mem_ctl_out", 64'(mem_ctl_out), 64'd0);
            check_field("type_out", 64'(type_out), 64'd0);
            check_field("op_32_out", 64'(op_32_out), 64'd0);
            check_field("jump_final", 64'(jump_final), 64'd0);
            cyc = cyc + 1;
            if (cyc > 40)
                abort_run("Timed out waiting for flush_internal to fall");
            @(negedge CLK);
        end
        cache_ready = 1'b1;
        check_field("flush cycles", n_flush, f[4]);
        check_field("flush_internal cycles", n_int, f[5]);
    endtask

    task automatic misalign_vector();
        alu_op     = alu_a;
        a          = f[2];
        mem_ctl_in = mem_ctl_t'(f[0][1:0]);
        ldst_type  = ldst_t'(f[1][2:0]);
        #4;
        check_field("load_misaligned", 64'(load_misaligned), f[3]);
        check_field("store_misaligned", 64'(store_misaligned), f[4]);
    endtask

    task automatic dispatch_vector();
        @(negedge CLK);
        drive_idle();
        wait_flush_clear();
        case (kind)
            "A":
            begin
                read_fields(5);
                alu_vector();
            end
            "B":
            begin
                read_fields(12);
                branch_vector();
            end
            "F":
            begin
                read_fields(6);
                flush_vector();
            end
            "M":
            begin
                read_fields(5);
                misalign_vector();
            end
            default: abort_run("Unknown record kind in trace file");
        endcase
        n_vec++;
    endtask

    //////////////////////////////////////////////////
    // Main sequence
    //////////////////////////////////////////////////

    initial
    begin
        CLK       = 1'b0;
        RST       = 1'b1;
        comp1     = '0;
        comp2     = '0;
        jump_bus1 = '0;
        jump_bus2 = '0;
        n_vec     = 0;
        done      = 1'b0;
        drive_idle();
        fd = $fopen("tests/ex_trace.txt", "r");
        if (fd == 0)
            abort_run("Could not open trace file tests/ex_trace.txt");
        repeat (3) @(posedge CLK);
        @(negedge CLK);
        RST = 1'b0;
        while (!done)
        begin
            code = $fscanf(fd, "%s", kind);
            if (code != 1)
                done = 1'b1;
            else if (kind == "#")
                code = $fgets(rest, fd);
            else
                dispatch_vector();
        end
        $fclose(fd);
        if (n_vec > 0)
        begin
            $display("TESTS PASSED");
            $finish;
        end
        else
        begin
            $display("No vectors were read from the trace file");
            $display("TESTS FAILED");
            $fatal(1);
        end
    end

endmodule

//--- tests/ex_trace.txt
# A alu_op op_32 a b wb_data | B fun3 cbranch jump jumpr comp1 comp2 bus1 bus2 pc_id_fb jf addr pred
# F bus1 bus2 pc_id_fb stall flush_cycles int_cycles | M mem_ctl ldst addr load_mis store_mis
A 0 0 5 7 c
A 1 0 7 5 fffffffffffffffe
A 2 0 3f 1 8000000000000000
A 3 0 3f 8000000000000000 1
A 4 0 3f 8000000000000000 ffffffffffffffff
A 5 0 ff00ff00ff00ff00 0ff00ff00ff00ff0 f0f0f0f0f0f0f0f0
A 6 0 f0 f ff
A 7 0 ff0 f0f f00
A 8 0 1 ffffffffffffffff 1
A 9 0 1 ffffffffffffffff 0
A a 0 123456789abcdef0 0 123456789abcdef0
A b 0 0 fedcba9876543210 fedcba9876543210
A c 0 0 1000 1004
A f 0 1 2 0
A 0 1 1 7fffffff ffffffff80000000
A 1 1 1 100000000 ffffffffffffffff
A 2 1 3f 1 ffffffff80000000
A 4 1 4 80000000 fffffffff8000000
B 0 1 0 0 5 5 1000 20 1020 1 1020 1
B 1 1 0 0 5 5 1000 20 1004 0 1020 1
B 4 1 0 0 ffffffffffffffff 1 2000 fffffffffffffff8 2004 1 1ff8 0
B 5 1 0 0 ffffffffffffffff 1 2000 8 2004 0 2008 1
B 6 1 0 0 ffffffffffffffff 1 2000 10 2004 0 2010 1
B 7 1 0 0 ffffffffffffffff 1 3000 10 3010 1 3010 1
B 3 1 0 0 5 5 1000 4 1004 0 1004 1
B 0 0 1 0 1 2 4000 100 4100 1 4100 1
B 0 0 0 1 1 2 4000 8 4000 1 4008 0
F 5000 100 5000 0 4 6
F 6000 40 6000 2 6 8
M 1 0 7 1 0
M 1 1 6 0 0
M 1 2 5 1 0
M 1 3 4 0 0
M 1 4 9 1 0
M 2 5 f 0 1
M 2 6 4 0 0
M 2 7 10 0 0
M 2 7 12 0 1
M 0 4 3 0 0

//--- verilog.f
common/ex_pkg.sv
alu/ex_alu.sv
branch/branch_unit.sv
source/flush_control.sv
source/misalign_check.sv
source/ex_stage.sv
tests/tb_ex_stage.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f verilog.f --top-module tb_ex_stage -o sim_ex_stage
./obj_dir/sim_ex_stage > sim.log 2>&1 || true
cat sim.log

if grep -q "TESTS PASSED" sim.log; then
    exit 0
fi
exit 1
